// File: source/isaPkg.sv
package isaPkg;

	// eight registers, r0 hardwired to zero
	localparam int REG_COUNT = 8;

	typedef logic [2:0] regAddrT;
	typedef logic [15:0] wordT;

	// opcode lives in the top nibble
	typedef enum logic [3:0] {
		NOP  = 4'h0,
		ADD  = 4'h1,
		SUB  = 4'h2,
		AND  = 4'h3,
		XOR  = 4'h4,
		ADDI = 4'h5,
		BEQZ = 4'h6,
		HALT = 4'hF
	} opcodeT;

	typedef struct packed {
		opcodeT opcode;
		regAddrT rd;
		regAddrT rs;
		regAddrT rt;
		logic [2:0] unused;
	} rFormatT;

	typedef struct packed {
		opcodeT opcode;
		regAddrT rd;
		regAddrT rs;
		logic [5:0] imm;
	} iFormatT;

	// same word seen as register or immediate layout
	typedef union packed {
		rFormatT rFormat;
		iFormatT iFormat;
	} instrU;

	localparam wordT NOP_WORD = 16'h0800;
	localparam wordT HALT_WORD = 16'hF000;

	function automatic logic writesRd(opcodeT op);
		return op inside {ADD, SUB, AND, XOR, ADDI};
	endfunction

	function automatic logic readsRt(opcodeT op);
		return op inside {ADD, SUB, AND, XOR};
	endfunction

	function automatic logic readsRs(opcodeT op);
		return writesRd(op) || (op == BEQZ);
	endfunction

	// addi immediate, sign extended
	function automatic wordT immValue(instrU instr);
		return {{10{instr.iFormat.imm[5]}}, instr.iFormat.imm};
	endfunction

	// beqz word offset from rd[1:0] and imm, sign extended
	function automatic wordT branchOffset(instrU instr);
		return {{8{instr.iFormat.rd[1]}}, instr.iFormat.rd[1:0], instr.iFormat.imm};
	endfunction

endpackage

// File: source/memPkg.sv
package memPkg;

	// program storage, one instruction per word
	localparam int MEM_WORDS = 256;
	localparam int ADDR_BITS = 8;

	typedef logic [ADDR_BITS-1:0] memAddrT;

	// held line geometry
	localparam int LINE_WORDS = 4;
	localparam int OFFSET_BITS = $clog2(LINE_WORDS);

	typedef logic [ADDR_BITS-1:OFFSET_BITS] tagT;

	// cycles a miss waits before the line is held
	localparam int MISS_CYCLES = 3;
	localparam int COUNT_BITS = $clog2(MISS_CYCLES + 1);

	typedef logic [COUNT_BITS-1:0] missCountT;

endpackage

// File: source/instructionMemory.sv
`timescale 1ns/1ps

module instructionMemory (
	input  logic clk,
	input  logic arstN,
	input  logic progWrite,
	input  memPkg::memAddrT progAddr,
	input  isaPkg::wordT progData,
	input  memPkg::memAddrT addr,
	output isaPkg::wordT data,
	output logic done
);

	isaPkg::wordT storage [memPkg::MEM_WORDS];
	memPkg::tagT heldTag;
	memPkg::tagT addrTag;
	memPkg::missCountT missCount;
	logic heldValid;
	logic hit;

	// line tag of the requested word
	assign addrTag = addr[memPkg::ADDR_BITS-1:memPkg::OFFSET_BITS];
	assign hit = heldValid && (heldTag == addrTag);

	// word comes straight out of storage, done only marks the hit
	assign data = storage[addr];
	assign done = hit;

	// program load port
	always_ff @(posedge clk) begin
		if (progWrite) begin
			storage[progAddr] <= progData;
		end
	end

	// hit register and miss counter
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			heldValid <= 1'b0;
			heldTag <= '0;
			missCount <= '0;
		end else if (progWrite) begin
			// new program, start cold
			heldValid <= 1'b0;
			missCount <= '0;
		end else if (!hit) begin
			if (missCount == memPkg::missCountT'(memPkg::MISS_CYCLES - 1)) begin
				// miss served, hold this line from now on
				heldValid <= 1'b1;
				heldTag <= addrTag;
				missCount <= '0;
			end else begin
				missCount <= missCount + 1'b1;
			end
		end else begin
			missCount <= '0;
		end
	end

endmodule

// File: source/fetchInstruction.sv
`timescale 1ns/1ps

module fetchInstruction (
	input  logic clk,
	input  logic arstN,
	input  logic run,
	input  logic halted,
	input  logic decodeStall,
	input  logic redirect,
	input  isaPkg::wordT redirectPc,
	output memPkg::memAddrT memAddr,
	input  isaPkg::wordT memData,
	input  logic memDone,
	output isaPkg::wordT fetchInstr,
	output logic fetchValid,
	output isaPkg::wordT fetchPc
);

	// byte address of the next instruction
	isaPkg::wordT pc;
	logic advance;

	// memory is word addressed
	assign memAddr = pc[memPkg::ADDR_BITS:1];

	// take the word only when everything downstream can accept it
	assign advance = run && !halted && memDone && !decodeStall;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			pc <= '0;
			fetchValid <= 1'b0;
		end else if (redirect) begin
			// branch taken, drop what was fetched
			pc <= redirectPc;
			fetchValid <= 1'b0;
		end else if (!decodeStall) begin
			fetchValid <= advance;
			if (advance) begin
				pc <= pc + 16'd2;
			end
		end
	end

	// fetch register payload, held while decode stalls
	always_ff @(posedge clk) begin
		if (redirect) begin
			fetchInstr <= isaPkg::NOP_WORD;
		end else if (!decodeStall) begin
			// memory still busy, hand a nop down
			fetchInstr <= advance ? memData : isaPkg::NOP_WORD;
			fetchPc <= pc;
		end
	end

endmodule

// File: source/decodeInstruction.sv
`timescale 1ns/1ps

module decodeInstruction (
	input  logic clk,
	input  logic arstN,
	input  isaPkg::wordT fetchInstr,
	input  logic fetchValid,
	input  isaPkg::wordT fetchPc,
	input  logic redirect,
	input  isaPkg::regAddrT exRd,
	input  logic exWrite,
	input  isaPkg::regAddrT resRd,
	input  logic resWrite,
	input  logic wbEn,
	input  isaPkg::regAddrT wbAddr,
	input  isaPkg::wordT wbData,
	output logic decodeStall,
	output isaPkg::wordT decInstr,
	output logic decValid,
	output isaPkg::wordT operandA,
	output isaPkg::wordT operandB,
	output isaPkg::wordT decPc
);

	isaPkg::wordT regFile [isaPkg::REG_COUNT];
	isaPkg::instrU instr;
	isaPkg::opcodeT opcode;
	isaPkg::regAddrT rs;
	isaPkg::regAddrT rt;
	logic useRs;
	logic useRt;
	logic hazardEx;
	logic hazardRes;
	logic bubble;

	// r0 reads zero, a write in this cycle is seen right away
	function automatic isaPkg::wordT readReg(isaPkg::regAddrT a);
		if (a == '0) begin
			return '0;
		end
		if (wbEn && (wbAddr == a)) begin
			return wbData;
		end
		return regFile[a];
	endfunction

	assign instr = fetchInstr;
	assign opcode = instr.rFormat.opcode;
	assign rs = instr.rFormat.rs;
	assign rt = instr.rFormat.rt;
	assign useRs = isaPkg::readsRs(opcode);
	assign useRt = isaPkg::readsRt(opcode);

	// raw check against older writers still in flight
	assign hazardEx = exWrite && ((useRs && (rs == exRd)) || (useRt && (rt == exRd)));
	assign hazardRes = resWrite && ((useRs && (rs == resRd)) || (useRt && (rt == resRd)));
	assign decodeStall = fetchValid && (hazardEx || hazardRes);

	// bubble on interlock or squash
	assign bubble = redirect || decodeStall;

	// register file, registers start from zero
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < isaPkg::REG_COUNT; i++) begin
				regFile[i] <= '0;
			end
		end else if (wbEn) begin
			regFile[wbAddr] <= wbData;
		end
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			decValid <= 1'b0;
		end else begin
			decValid <= fetchValid && !bubble;
		end
	end

	// decode to execute payload
	always_ff @(posedge clk) begin
		decInstr <= bubble ? isaPkg::NOP_WORD : fetchInstr;
		operandA <= readReg(rs);
		operandB <= readReg(rt);
		decPc <= fetchPc;
	end

endmodule

// File: source/executeInstruction.sv
`timescale 1ns/1ps

module executeInstruction (
	input  logic clk,
	input  logic arstN,
	input  isaPkg::wordT decInstr,
	input  logic decValid,
	input  isaPkg::wordT operandA,
	input  isaPkg::wordT operandB,
	input  isaPkg::wordT pcOfInstr,
	output isaPkg::regAddrT exRd,
	output logic exWrite,
	output logic redirect,
	output isaPkg::wordT redirectPc,
	output logic resValid,
	output logic resWrite,
	output isaPkg::regAddrT resRd,
	output isaPkg::wordT resData,
	output logic resHalt
);

	isaPkg::instrU instr;
	isaPkg::opcodeT opcode;
	isaPkg::wordT aluOut;

	assign instr = decInstr;
	assign opcode = instr.rFormat.opcode;

	// writer seen by the decode interlock, r0 never counts
	assign exRd = instr.rFormat.rd;
	assign exWrite = decValid && isaPkg::writesRd(opcode) && (exRd != '0);

	always_comb begin
		case (opcode)
			isaPkg::ADD:  aluOut = operandA + operandB;
			isaPkg::SUB:  aluOut = operandA - operandB;
			isaPkg::AND:  aluOut = operandA & operandB;
			isaPkg::XOR:  aluOut = operandA ^ operandB;
			isaPkg::ADDI: aluOut = operandA + isaPkg::immValue(instr);
			default:      aluOut = '0;
		endcase
	end

	// beqz tests rs, target relative to the next instruction
	assign redirect = decValid && (opcode == isaPkg::BEQZ) && (operandA == '0);
	assign redirectPc = pcOfInstr + 16'd2 + (isaPkg::branchOffset(instr) << 1);

	// the branch itself goes on, younger work is squashed upstream
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			resValid <= 1'b0;
			resWrite <= 1'b0;
			resHalt <= 1'b0;
		end else begin
			resValid <= decValid;
			resWrite <= exWrite;
			resHalt <= decValid && (opcode == isaPkg::HALT);
		end
	end

	// execute to result payload
	always_ff @(posedge clk) begin
		resRd <= exRd;
		resData <= aluOut;
	end

endmodule

// File: source/resultWriteback.sv
`timescale 1ns/1ps

module resultWriteback (
	input  logic clk,
	input  logic arstN,
	input  logic resValid,
	input  logic resWrite,
	input  isaPkg::regAddrT resRd,
	input  isaPkg::wordT resData,
	input  logic resHalt,
	output logic wbEn,
	output isaPkg::regAddrT wbAddr,
	output isaPkg::wordT wbData,
	output logic retireValid,
	output isaPkg::regAddrT retireRd,
	output isaPkg::wordT retireData,
	output logic retireWrite,
	output logic halted
);

	// anything behind a retired halt is dropped
	assign retireValid = resValid && !halted;
	assign retireRd = resRd;
	assign retireData = resData;
	assign retireWrite = resWrite;

	// r0 is never written
	assign wbEn = retireValid && resWrite && (resRd != '0);
	assign wbAddr = resRd;
	assign wbData = resData;

	// sticky until reset
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			halted <= 1'b0;
		end else if (retireValid && resHalt) begin
			halted <= 1'b1;
		end
	end

endmodule

// File: source/cpuCore.sv
`timescale 1ns/1ps

module cpuCore (
	input  logic clk,
	input  logic arstN,
	input  logic run,
	input  logic progWrite,
	input  memPkg::memAddrT progAddr,
	input  isaPkg::wordT progData,
	output logic retireValid,
	output isaPkg::regAddrT retireRd,
	output isaPkg::wordT retireData,
	output logic retireWrite,
	output logic halted
);

	// fetch and memory
	memPkg::memAddrT memAddr;
	isaPkg::wordT memData;
	logic memDone;

	// fetch to decode
	isaPkg::wordT fetchInstr;
	isaPkg::wordT fetchPc;
	logic fetchValid;
	logic decodeStall;

	// decode to execute
	isaPkg::wordT decInstr;
	isaPkg::wordT operandA;
	isaPkg::wordT operandB;
	isaPkg::wordT decPc;
	logic decValid;

	// execute outputs
	isaPkg::regAddrT exRd;
	logic exWrite;
	logic redirect;
	isaPkg::wordT redirectPc;
	logic resValid;
	logic resWrite;
	isaPkg::regAddrT resRd;
	isaPkg::wordT resData;
	logic resHalt;

	// writeback into the register file
	logic wbEn;
	isaPkg::regAddrT wbAddr;
	isaPkg::wordT wbData;

	instructionMemory instructionMemory (
		.clk(clk), .arstN(arstN),
		.progWrite(progWrite), .progAddr(progAddr), .progData(progData),
		.addr(memAddr), .data(memData), .done(memDone)
	);

	fetchInstruction fetchInstruction (
		.clk(clk), .arstN(arstN), .run(run), .halted(halted),
		.decodeStall(decodeStall), .redirect(redirect), .redirectPc(redirectPc),
		.memAddr(memAddr), .memData(memData), .memDone(memDone),
		.fetchInstr(fetchInstr), .fetchValid(fetchValid), .fetchPc(fetchPc)
	);

	decodeInstruction decodeInstruction (
		.clk(clk), .arstN(arstN),
		.fetchInstr(fetchInstr), .fetchValid(fetchValid), .fetchPc(fetchPc),
		.redirect(redirect), .exRd(exRd), .exWrite(exWrite),
		.resRd(resRd), .resWrite(resWrite),
		.wbEn(wbEn), .wbAddr(wbAddr), .wbData(wbData),
		.decodeStall(decodeStall), .decInstr(decInstr), .decValid(decValid),
		.operandA(operandA), .operandB(operandB), .decPc(decPc)
	);

	// pc of the instruction in execute comes from the decode register
	executeInstruction executeInstruction (
		.clk(clk), .arstN(arstN),
		.decInstr(decInstr), .decValid(decValid),
		.operandA(operandA), .operandB(operandB), .pcOfInstr(decPc),
		.exRd(exRd), .exWrite(exWrite),
		.redirect(redirect), .redirectPc(redirectPc),
		.resValid(resValid), .resWrite(resWrite), .resRd(resRd),
		.resData(resData), .resHalt(resHalt)
	);

	resultWriteback resultWriteback (
		.clk(clk), .arstN(arstN),
		.resValid(resValid), .resWrite(resWrite), .resRd(resRd),
		.resData(resData), .resHalt(resHalt),
		.wbEn(wbEn), .wbAddr(wbAddr), .wbData(wbData),
		.retireValid(retireValid), .retireRd(retireRd),
		.retireData(retireData), .retireWrite(retireWrite), .halted(halted)
	);

endmodule

// File: test/cpuCoreSva.sv
`timescale 1ns/1ps

module cpuCoreSva (
	input logic clk,
	input logic arstN,
	input logic retireValid,
	input logic halted,
	input logic decodeStall,
	input logic redirect,
	input isaPkg::wordT fetchInstr
);

	// read by the testbench when the run ends
	int failCount = 0;

	// nothing retires or halts straight out of reset
	resetQuiet: assert property (
		@(posedge clk) !arstN |=> (!retireValid && !halted)
	) else begin
		failCount++;
		$error("retireValid or halted high after reset");
	end

	// a stalled decode keeps its fetch register unless a branch squashes it
	stallHolds: assert property (
		@(posedge clk) disable iff (!arstN)
		(decodeStall && !redirect) |=> $stable(fetchInstr)
	) else begin
		failCount++;
		$error("fetchInstr changed while decode was stalled");
	end

	// no retirement once halted
	noRetireAfterHalt: assert property (
		@(posedge clk) disable iff (!arstN) halted |-> !retireValid
	) else begin
		failCount++;
		$error("retireValid high after halted");
	end

endmodule

// File: test/cpuCoreTb.sv
`timescale 1ns/1ps

module cpuCoreTb;

	localparam int CLK_NS = 4;
	localparam int PROG_COUNT = 12;
	localparam int PROG_LEN = 24;
	// fetch runs a few words ahead of the retiring halt
	localparam int PAD_WORDS = 4;
	// per loaded word, one miss plus pipeline and stall slack
	localparam int WATCHDOG_CYCLES =
		PROG_COUNT * (PROG_LEN + PAD_WORDS) * (memPkg::MISS_CYCLES + 6);

	logic clk;
	logic arstN;
	logic run;
	logic progWrite;
	memPkg::memAddrT progAddr;
	isaPkg::wordT progData;
	logic retireValid;
	isaPkg::regAddrT retireRd;
	isaPkg::wordT retireData;
	logic retireWrite;
	logic halted;

	logic [31:0] rngState = 32'd26529;
	isaPkg::wordT progWords [PROG_LEN];
	// architectural registers of the model
	isaPkg::wordT modelRegs [isaPkg::REG_COUNT];
	int modelIdx;
	logic haltRetired;

	cpuCore UUT (
		.clk(clk), .arstN(arstN), .run(run),
		.progWrite(progWrite), .progAddr(progAddr), .progData(progData),
		.retireValid(retireValid), .retireRd(retireRd), .retireData(retireData),
		.retireWrite(retireWrite), .halted(halted)
	);

	bind cpuCore cpuCoreSva coreChecks (
		.clk(clk), .arstN(arstN), .retireValid(retireValid), .halted(halted),
		.decodeStall(decodeStall), .redirect(redirect), .fetchInstr(fetchInstr)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#(CLK_NS / 2) clk = ~clk;
		end
	end

	// xorshift32
	function automatic logic [31:0] nextRandom();
		rngState ^= rngState << 13;
		rngState ^= rngState >> 17;
		rngState ^= rngState << 5;
		return rngState;
	endfunction

	task automatic failRun();
		$display("Finished with errors");
		$fatal(1, "simulation stopped at the first failure");
	endtask

	task automatic compareRd(isaPkg::regAddrT got, isaPkg::regAddrT expected);
		if (got !== expected) begin
			$display("Error: retireRd is %h, expected %h", got, expected);
			failRun();
		end
	endtask

	task automatic compareData(isaPkg::wordT got, isaPkg::wordT expected);
		if (got !== expected) begin
			$display("Error: retireData is %h, expected %h", got, expected);
			failRun();
		end
	endtask

	task automatic compareFlag(string name, logic got, logic expected);
		if (got !== expected) begin
			$display("Error: %s is %h, expected %h", name, got, expected);
			failRun();
		end
	endtask

	// random body, halt at the end
	task automatic buildProgram();
		isaPkg::instrU ins;
		logic [31:0] r;
		int off;
		for (int i = 0; i < PROG_LEN - 1; i++) begin
			r = nextRandom();
			ins = '0;
			ins.rFormat.rd = r[2:0];
			ins.rFormat.rs = r[5:3];
			ins.rFormat.rt = r[8:6];
			case (r[11:9])
				3'd0: ins.rFormat.opcode = isaPkg::ADD;
				3'd1: ins.rFormat.opcode = isaPkg::SUB;
				3'd2: ins.rFormat.opcode = isaPkg::AND;
				3'd3: ins.rFormat.opcode = isaPkg::XOR;
				3'd4, 3'd5: begin
					ins.iFormat.opcode = isaPkg::ADDI;
					ins.iFormat.imm = r[17:12];
				end
				3'd6: begin
					// forward only, never past the closing halt
					off = int'(r[22:18]) % (PROG_LEN - 1 - i);
					ins.iFormat.opcode = isaPkg::BEQZ;
					ins.iFormat.rd = 3'(off >> 6);
					// r0 half the time so plenty of branches are taken
					ins.iFormat.rs = r[23] ? 3'd0 : r[5:3];
					ins.iFormat.imm = 6'(off);
				end
				default: ins = isaPkg::NOP_WORD;
			endcase
			progWords[i] = ins;
		end
		progWords[PROG_LEN - 1] = isaPkg::HALT_WORD;
	endtask

	task automatic resetCore();
		@(negedge clk);
		arstN = 1'b0;
		repeat (2) @(negedge clk);
		arstN = 1'b1;
	endtask

	// program from word 0, halts behind it
	task automatic loadProgram();
		for (int i = 0; i < PROG_LEN + PAD_WORDS; i++) begin
			@(negedge clk);
			progWrite = 1'b1;
			progAddr = memPkg::memAddrT'(i);
			progData = (i < PROG_LEN) ? progWords[i] : isaPkg::HALT_WORD;
		end
		@(negedge clk);
		progWrite = 1'b0;
		run = 1'b1;
	endtask

	// one architectural step per retirement, timing ignored
	task automatic modelStep();
		isaPkg::instrU ins;
		isaPkg::wordT a;
		isaPkg::wordT b;
		isaPkg::wordT value;
		logic writes;
		ins = progWords[modelIdx];
		a = modelRegs[ins.rFormat.rs];
		b = modelRegs[ins.rFormat.rt];
		value = '0;
		writes = 1'b1;
		case (ins.rFormat.opcode)
			isaPkg::ADD: value = a + b;
			isaPkg::SUB: value = a - b;
			isaPkg::AND: value = a & b;
			isaPkg::XOR: value = a ^ b;
			// six bit immediate, sign extended
			isaPkg::ADDI: value = a + {{10{ins.iFormat.imm[5]}}, ins.iFormat.imm};
			default: writes = 1'b0;
		endcase
		if (writes) begin
			compareRd(retireRd, ins.rFormat.rd);
			compareData(retireData, value);
		end
		// r0 targets retire without a register write
		compareFlag("retireWrite", retireWrite, writes && (ins.rFormat.rd != '0));
		if (writes && (ins.rFormat.rd != '0)) begin
			modelRegs[ins.rFormat.rd] = value;
		end
		if ((ins.rFormat.opcode == isaPkg::BEQZ) && (a == '0)) begin
			// taken, word offset from rd[1:0] and imm
			modelIdx = modelIdx + 1 + int'($signed({ins.iFormat.rd[1:0], ins.iFormat.imm}));
		end else begin
			modelIdx = modelIdx + 1;
		end
		haltRetired = (ins.rFormat.opcode == isaPkg::HALT);
	endtask

	task automatic runProgram();
		for (int r = 0; r < isaPkg::REG_COUNT; r++) begin
			modelRegs[r] = '0;
		end
		modelIdx = 0;
		haltRetired = 1'b0;
		// retire outputs settle after the rising edge
		while (!haltRetired) begin
			@(negedge clk);
			if (retireValid) begin
				modelStep();
			end
		end
		@(negedge clk);
		compareFlag("halted", halted, 1'b1);
		// fetch frozen, nothing more may retire
		repeat (2 * memPkg::LINE_WORDS) begin
			@(negedge clk);
			if (retireValid) begin
				$display("a retirement was seen after the core halted");
				failRun();
			end
		end
		run = 1'b0;
	endtask

	initial begin
		arstN = 1'b0;
		run = 1'b0;
		progWrite = 1'b0;
		progAddr = '0;
		progData = '0;
		for (int p = 0; p < PROG_COUNT; p++) begin
			buildProgram();
			resetCore();
			loadProgram();
			runProgram();
		end
		if (UUT.coreChecks.failCount == 0) begin
			$display("Finished with no errors");
			$finish;
		end else begin
			$display("%0d assertion failures were reported", UUT.coreChecks.failCount);
			failRun();
		end
	end

	// watchdog
	initial begin
		#(WATCHDOG_CYCLES * CLK_NS);
		$display("watchdog expired before all programs halted");
		failRun();
	end

endmodule

// File: sim.f
source/isaPkg.sv
source/memPkg.sv
source/instructionMemory.sv
source/fetchInstruction.sv
source/decodeInstruction.sv
source/executeInstruction.sv
source/resultWriteback.sv
source/cpuCore.sv
test/cpuCoreSva.sv
test/cpuCoreTb.sv

// File: Makefile
# Verilator build and run for the cpuCore testbench

VERILATOR ?= verilator
TOP ?= cpuCoreTb
FILELIST ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal
PASS_MSG ?= Finished with no errors

SOURCES := $(wildcard source/*.sv test/*.sv)
BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# the binary is rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# pass or fail comes from the pass line in the simulator output
run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
